/* src.f */
mcu_pkg.sv
obi_if.sv
system_bus.sv
ram_bank.sv
soc_ctrl.sv
gpio_ctrl.sv
fast_intr_ctrl.sv
core_v_mini_mcu.sv
mcu_checker.sv
tb_core_v_mini_mcu.sv

/* Makefile */
# Verilator build and run of the MCU bus testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vtb_core_v_mini_mcu: src.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_core_v_mini_mcu -f src.f

test: obj_dir/Vtb_core_v_mini_mcu
	./obj_dir/Vtb_core_v_mini_mcu > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* tb_core_v_mini_mcu.sv */
/*
  Table-driven bus testbench for the MCU bus side, default parameters.
  Responses are checked on the falling edge exactly one cycle after each request.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_core_v_mini_mcu;

  localparam int RAM_WORDS = 256;
  localparam int NEXT_INT  = 4;

  typedef enum logic [3:0] {
    OP_WRITE,
    OP_READ,
    OP_PINS,
    OP_GPIO_OUT,
    OP_GPIO_EN,
    OP_EXIT_VAL,
    OP_EXIT_FLAG,
    OP_IRQ
  } op_e;

  typedef struct packed {
    op_e                 op;
    mcu_pkg::addr_t      addr;
    mcu_pkg::data_t      wdata;
    mcu_pkg::be_t        be;
    mcu_pkg::gpio_t      pins;
    logic [NEXT_INT-1:0] ext;
    logic                boot;
    mcu_pkg::data_t      exp;
    logic [3:0]          wait_n;
  } entry_t;

  logic                clk_i;
  logic                rst_i;
  logic                bus_req_i;
  logic                bus_we_i;
  mcu_pkg::be_t        bus_be_i;
  mcu_pkg::addr_t      bus_addr_i;
  mcu_pkg::data_t      bus_wdata_i;
  logic                bus_gnt_o;
  logic                bus_rvalid_o;
  mcu_pkg::data_t      bus_rdata_o;
  logic                boot_select_i;
  mcu_pkg::gpio_t      gpio_i;
  logic [NEXT_INT-1:0] intr_ext_i;
  mcu_pkg::gpio_t      gpio_o;
  mcu_pkg::gpio_t      gpio_en_o;
  logic                exit_valid_o;
  mcu_pkg::data_t      exit_value_o;
  mcu_pkg::irq_vec_t   irq_o;

  entry_t         tbl [$];
  logic [15:0]    lfsr_q;
  int             errors;
  int             checks;
  int             cycles;
  int             limit;
  logic           resp_pending;
  mcu_pkg::data_t resp_exp;
  mcu_pkg::addr_t resp_addr;

  core_v_mini_mcu #(
    .RAM_WORDS(RAM_WORDS),
    .NEXT_INT (NEXT_INT)
  ) DUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_be_i     (bus_be_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .boot_select_i(boot_select_i),
    .gpio_i       (gpio_i),
    .intr_ext_i   (intr_ext_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o),
    .irq_o        (irq_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output mcu_pkg::data_t w);
    int k;
    w = '0;
    for (k = 0; k < 32; k++) begin
      w = {w[30:0], lfsr_q[15]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // bytes with their enable set come from the new word
  function automatic mcu_pkg::data_t merge_bytes(input mcu_pkg::data_t old_w,
                                                 input mcu_pkg::data_t new_w,
                                                 input mcu_pkg::be_t be);
    mcu_pkg::data_t r;
    int b;
    r = old_w;
    for (b = 0; b < 4; b++) begin
      if (be[b]) begin
        r[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_data(input string what, input mcu_pkg::data_t got,
                            input mcu_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_gpio(input string what, input mcu_pkg::gpio_t got,
                            input mcu_pkg::gpio_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input mcu_pkg::irq_vec_t got, input mcu_pkg::irq_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: irq_o is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic add_bus(input op_e op, input mcu_pkg::addr_t addr,
                         input mcu_pkg::data_t wdata, input mcu_pkg::be_t be,
                         input mcu_pkg::data_t exp, input logic [3:0] wait_n);
    tbl.push_back('{op, addr, wdata, be, '0, '0, 1'b0, exp, wait_n});
  endtask

  task automatic add_pins(input mcu_pkg::gpio_t pins, input logic [NEXT_INT-1:0] ext,
                          input logic boot, input logic [3:0] wait_n);
    tbl.push_back('{OP_PINS, '0, '0, '0, pins, ext, boot, '0, wait_n});
  endtask

  task automatic add_check(input op_e op, input mcu_pkg::data_t exp);
    tbl.push_back('{op, '0, '0, '0, '0, '0, 1'b0, exp, 4'd0});
  endtask

  task automatic build_table();
    mcu_pkg::data_t w;
    mcu_pkg::data_t model [8];
    mcu_pkg::be_t   pat [4];
    mcu_pkg::gpio_t pins;
    mcu_pkg::data_t out_w;
    mcu_pkg::data_t en_w;
    int i;
    pat = '{4'b0001, 4'b0110, 4'b1000, 4'b0000};
    // back to back ram words then partial writes
    for (i = 0; i < 8; i++) begin
      rand_word(w);
      model[i] = w;
      add_bus(OP_WRITE, mcu_pkg::addr_t'(i * 4), w, 4'hF, '0, 4'd0);
    end
    for (i = 0; i < 8; i++) begin
      add_bus(OP_READ, mcu_pkg::addr_t'(i * 4), '0, 4'hF, model[i], 4'd0);
    end
    for (i = 0; i < 4; i++) begin
      rand_word(w);
      model[i] = merge_bytes(model[i], w, pat[i]);
      add_bus(OP_WRITE, mcu_pkg::addr_t'(i * 4), w, pat[i], '0, 4'd0);
    end
    for (i = 0; i < 4; i++) begin
      add_bus(OP_READ, mcu_pkg::addr_t'(i * 4), '0, 4'hF, model[i], 4'd0);
    end
    rand_word(w);
    add_bus(OP_WRITE, 32'h0000_03FC, w, 4'hF, '0, 4'd0);
    add_bus(OP_READ, 32'h0000_03FC, '0, 4'hF, w, 4'd0);
    // soc control
    add_check(OP_EXIT_FLAG, 32'd0);
    rand_word(w);
    add_bus(OP_WRITE, 32'h2000_0004, w, 4'hF, '0, 4'd0);
    add_bus(OP_WRITE, 32'h2000_0000, 32'd1, 4'hF, '0, 4'd0);
    add_check(OP_EXIT_VAL, w);
    add_check(OP_EXIT_FLAG, 32'd1);
    add_bus(OP_READ, 32'h2000_0004, '0, 4'hF, w, 4'd0);
    add_bus(OP_READ, 32'h2000_0008, '0, 4'hF, 32'd1, 4'd0);
    // boot select pin low while exit_valid stays high
    add_pins('0, '0, 1'b0, 4'd0);
    add_bus(OP_READ, 32'h2000_0008, '0, 4'hF, 32'd0, 4'd0);
    // gpio outputs and input sampling
    rand_word(out_w);
    rand_word(en_w);
    add_bus(OP_WRITE, 32'h2000_1004, out_w, 4'hF, '0, 4'd0);
    add_bus(OP_WRITE, 32'h2000_1008, en_w, 4'hF, '0, 4'd0);
    add_check(OP_GPIO_OUT, out_w);
    add_check(OP_GPIO_EN, en_w);
    rand_word(pins);
    pins = pins & 32'hFFFF_FF00;
    add_pins(pins, '0, 1'b0, 4'd2);
    add_bus(OP_READ, 32'h2000_1000, '0, 4'hF, pins, 4'd0);
    // rising edge on pin 3 reaches fast line 9 and vector bit 25
    add_bus(OP_WRITE, 32'h2000_100C, 32'h0000_0008, 4'hF, '0, 4'd0);
    add_bus(OP_WRITE, 32'h2000_2004, 32'h0000_0200, 4'hF, '0, 4'd0);
    add_check(OP_IRQ, 32'd0);
    add_pins(pins | 32'h0000_0008, '0, 1'b0, 4'd6);
    add_check(OP_IRQ, 32'h0200_0000);
    add_bus(OP_READ, 32'h2000_1010, '0, 4'hF, 32'h0000_0008, 4'd0);
    add_bus(OP_READ, 32'h2000_2000, '0, 4'hF, 32'h0000_0200, 4'd0);
    add_bus(OP_WRITE, 32'h2000_1010, 32'h0000_0008, 4'hF, '0, 4'd1);
    add_bus(OP_WRITE, 32'h2000_2000, 32'h0000_0200, 4'hF, '0, 4'd2);
    add_check(OP_IRQ, 32'd0);
    add_bus(OP_READ, 32'h2000_1010, '0, 4'hF, 32'd0, 4'd0);
    // external level on bit 11 and latched on fast line 14
    add_pins(pins | 32'h0000_0008, 4'b0100, 1'b0, 4'd3);
    add_check(OP_IRQ, 32'h0000_0800);
    add_bus(OP_WRITE, 32'h2000_2004, 32'h0000_4200, 4'hF, '0, 4'd2);
    add_check(OP_IRQ, 32'h4000_0800);
    add_pins(pins | 32'h0000_0008, '0, 1'b0, 4'd1);
    add_bus(OP_WRITE, 32'h2000_2000, 32'h0000_4000, 4'hF, '0, 4'd2);
    add_check(OP_IRQ, 32'd0);
    // unmapped reads mixed with a ram read
    add_bus(OP_READ, 32'h2000_3000, '0, 4'hF, 32'd0, 4'd0);
    add_bus(OP_READ, 32'h3000_0000, '0, 4'hF, 32'd0, 4'd0);
    add_bus(OP_READ, 32'h0000_0400, '0, 4'hF, 32'd0, 4'd0);
    add_bus(OP_READ, 32'h0000_0000, '0, 4'hF, model[0], 4'd0);
    add_bus(OP_WRITE, 32'hFFFF_FFF0, 32'h1234_5678, 4'hF, '0, 4'd0);
  endtask

  task automatic collect_response();
    if (resp_pending) begin
      if (!bus_rvalid_o) begin
        errors++;
        $display("missing response: no rvalid one cycle after the request to %h at %0t",
                 resp_addr, $time);
      end else begin
        check_data("bus_rdata_o", bus_rdata_o, resp_exp);
      end
    end else if (bus_rvalid_o) begin
      errors++;
      $display("unexpected rvalid with no request outstanding at %0t", $time);
    end
    resp_pending = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    collect_response();
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    next_cycle();
    case (e.op)
      OP_WRITE, OP_READ: begin
        bus_req_i    = 1'b1;
        bus_we_i     = (e.op == OP_WRITE);
        bus_be_i     = e.be;
        bus_addr_i   = e.addr;
        bus_wdata_i  = e.wdata;
        resp_pending = 1'b1;
        resp_exp     = e.exp;
        resp_addr    = e.addr;
      end
      OP_PINS: begin
        gpio_i        = e.pins;
        intr_ext_i    = e.ext;
        boot_select_i = e.boot;
      end
      OP_GPIO_OUT:  check_gpio("gpio_o", gpio_o, mcu_pkg::gpio_t'(e.exp));
      OP_GPIO_EN:   check_gpio("gpio_en_o", gpio_en_o, mcu_pkg::gpio_t'(e.exp));
      OP_EXIT_VAL:  check_data("exit_value_o", exit_value_o, e.exp);
      OP_EXIT_FLAG: check_data("exit_valid_o", mcu_pkg::data_t'(exit_valid_o), e.exp);
      OP_IRQ:       check_irq(irq_o, mcu_pkg::irq_vec_t'(e.exp));
      default: ;
    endcase
    repeat (e.wait_n) next_cycle();
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    bus_req_i     = 1'b0;
    bus_we_i      = 1'b0;
    bus_be_i      = '0;
    bus_addr_i    = '0;
    bus_wdata_i   = '0;
    boot_select_i = 1'b1;
    gpio_i        = '0;
    intr_ext_i    = '0;
    lfsr_q        = 16'd51;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    limit         = 0;
    resp_pending  = 1'b0;
    resp_exp      = '0;
    resp_addr     = '0;
    build_table();
    limit = tbl.size() * 8 + 50;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    foreach (tbl[i]) begin
      apply_entry(tbl[i]);
    end
    next_cycle();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mcu_checker.sv */
/*
  Bus handshake and reset properties of the MCU top level, bound into it.
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_checker (
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_i,
  input logic              gnt_i,
  input logic              rvalid_i,
  input logic              exit_valid_i,
  input mcu_pkg::irq_vec_t irq_i
);

  gnt_same_cycle: assert property (@(posedge clk_i) gnt_i == req_i)
    else $error("bus grant differs from bus request");

  // exactly one rvalid per request, one cycle later
  rvalid_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i == $past(req_i))
    else $error("bus rvalid does not follow the request by one cycle");

  reset_outputs_low: assert property (@(posedge clk_i)
    rst_i |=> (irq_i == '0 && !exit_valid_i && !rvalid_i))
    else $error("outputs not cleared by reset");

endmodule

bind core_v_mini_mcu mcu_checker mcu_checker_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_i       (bus_req_i),
  .gnt_i       (bus_gnt_o),
  .rvalid_i    (bus_rvalid_o),
  .exit_valid_i(exit_valid_o),
  .irq_i       (irq_o)
);

`default_nettype wire

/* core_v_mini_mcu.sv */
/*
  Bus side of the mini MCU: one master port, RAM and three register blocks.
  No CPU, pads or power domains; all pins are plain inputs and outputs.
*/
`timescale 1ns/1ps
`default_nettype none

module core_v_mini_mcu #(
  parameter int RAM_WORDS = 256,
  parameter int NEXT_INT  = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              bus_req_i,
  input  logic              bus_we_i,
  input  mcu_pkg::be_t      bus_be_i,
  input  mcu_pkg::addr_t    bus_addr_i,
  input  mcu_pkg::data_t    bus_wdata_i,
  output logic              bus_gnt_o,
  output logic              bus_rvalid_o,
  output mcu_pkg::data_t    bus_rdata_o,
  input  logic              boot_select_i,
  input  mcu_pkg::gpio_t    gpio_i,
  input  logic [NEXT_INT-1:0] intr_ext_i,
  output mcu_pkg::gpio_t    gpio_o,
  output mcu_pkg::gpio_t    gpio_en_o,
  output logic              exit_valid_o,
  output mcu_pkg::data_t    exit_value_o,
  output mcu_pkg::irq_vec_t irq_o
);

  logic [mcu_pkg::GPIO_INTR_NUM-1:0] gpio_intr;

  obi_if ram_if ();
  obi_if soc_if ();
  obi_if gpio_if ();
  obi_if intr_if ();

  system_bus #(
    .RAM_WORDS(RAM_WORDS)
  ) system_bus_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_be_i    (bus_be_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_gnt_o   (bus_gnt_o),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o (bus_rdata_o),
    .ram_o       (ram_if.mgr),
    .soc_o       (soc_if.mgr),
    .gpio_o      (gpio_if.mgr),
    .intr_o      (intr_if.mgr)
  );

  ram_bank #(
    .RAM_WORDS(RAM_WORDS)
  ) ram_bank_i (
    .clk_i(clk_i),
    .bus_s(ram_if.sub)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .boot_select_i(boot_select_i),
    .bus_s        (soc_if.sub),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

  gpio_ctrl gpio_ctrl_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .gpio_i     (gpio_i),
    .bus_s      (gpio_if.sub),
    .gpio_o     (gpio_o),
    .gpio_en_o  (gpio_en_o),
    .gpio_intr_o(gpio_intr)
  );

  fast_intr_ctrl #(
    .NEXT_INT(NEXT_INT)
  ) fast_intr_ctrl_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .gpio_intr_i(gpio_intr),
    .intr_ext_i (intr_ext_i),
    .bus_s      (intr_if.sub),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

/* fast_intr_ctrl.sv */
/*
  Latches fast interrupt events and builds the core interrupt vector.
  Fast lines 5:0 and vector bits other than 30:16 and 11 are always zero.
*/
`timescale 1ns/1ps
`default_nettype none

module fast_intr_ctrl #(
  parameter int NEXT_INT = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [mcu_pkg::GPIO_INTR_NUM-1:0] gpio_intr_i,
  input  logic [NEXT_INT-1:0]               intr_ext_i,
  obi_if.sub                                bus_s,
  output mcu_pkg::irq_vec_t                 irq_o
);

  mcu_pkg::fast_irq_t src;
  mcu_pkg::fast_irq_t pending_q;
  mcu_pkg::fast_irq_t enable_q;
  mcu_pkg::fast_irq_t pend_clr;
  mcu_pkg::irq_vec_t  irq_d;
  logic [11:0]        ofs;
  logic               wr;

  assign ofs = bus_s.addr[11:0];
  assign wr  = bus_s.req && bus_s.we;

  assign pend_clr = (wr && ofs == mcu_pkg::FAST_PENDING_OFS) ?
                    bus_s.wdata[$bits(mcu_pkg::fast_irq_t)-1:0] : '0;

  always_comb begin
    src = '0;
    src[mcu_pkg::FAST_GPIO_LSB +: mcu_pkg::GPIO_INTR_NUM] = gpio_intr_i;
    src[mcu_pkg::FAST_EXT_LINE] = |intr_ext_i;
  end

  // reference vector layout
  always_comb begin
    irq_d = '0;
    irq_d[mcu_pkg::IRQ_FAST_LSB +: $bits(mcu_pkg::fast_irq_t)] = pending_q & enable_q;
    irq_d[mcu_pkg::IRQ_EXT_BIT] = |intr_ext_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      irq_o        <= '0;
      bus_s.rvalid <= 1'b0;
    end else begin
      pending_q    <= (pending_q & ~pend_clr) | src;
      irq_o        <= irq_d;
      bus_s.rvalid <= bus_s.req;
      if (wr && ofs == mcu_pkg::FAST_ENABLE_OFS) begin
        enable_q <= bus_s.wdata[$bits(mcu_pkg::fast_irq_t)-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      bus_s.rdata <= '0;
      if (!bus_s.we) begin
        case (ofs)
          mcu_pkg::FAST_PENDING_OFS: bus_s.rdata <= mcu_pkg::data_t'(pending_q);
          mcu_pkg::FAST_ENABLE_OFS:  bus_s.rdata <= mcu_pkg::data_t'(enable_q);
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* gpio_ctrl.sv */
/*
  32-pin GPIO with output enable. Only pins 7:0 raise rising-edge interrupts.
  Status bits are cleared by writing ones; a new edge in the same cycle wins.
*/
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  mcu_pkg::gpio_t                    gpio_i,
  obi_if.sub                                bus_s,
  output mcu_pkg::gpio_t                    gpio_o,
  output mcu_pkg::gpio_t                    gpio_en_o,
  output logic [mcu_pkg::GPIO_INTR_NUM-1:0] gpio_intr_o
);

  localparam int N = mcu_pkg::GPIO_INTR_NUM;

  mcu_pkg::gpio_t in_q;
  logic [N-1:0]   in_d;
  logic [N-1:0]   rise;
  logic [N-1:0]   intr_en_q;
  logic [N-1:0]   status_q;
  logic [N-1:0]   status_clr;
  logic [11:0]    ofs;
  logic           wr;

  assign ofs  = bus_s.addr[11:0];
  assign wr   = bus_s.req && bus_s.we;
  assign rise = in_q[N-1:0] & ~in_d;

  assign status_clr = (wr && ofs == mcu_pkg::GPIO_INTR_STATUS_OFS) ? bus_s.wdata[N-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_q         <= '0;
      in_d         <= '0;
      gpio_o       <= '0;
      gpio_en_o    <= '0;
      intr_en_q    <= '0;
      status_q     <= '0;
      bus_s.rvalid <= 1'b0;
    end else begin
      in_q         <= gpio_i;
      in_d         <= in_q[N-1:0];
      status_q     <= (status_q & ~status_clr) | rise;
      bus_s.rvalid <= bus_s.req;
      if (wr) begin
        case (ofs)
          mcu_pkg::GPIO_OUT_OFS:     gpio_o    <= bus_s.wdata;
          mcu_pkg::GPIO_EN_OFS:      gpio_en_o <= bus_s.wdata;
          mcu_pkg::GPIO_INTR_EN_OFS: intr_en_q <= bus_s.wdata[N-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      bus_s.rdata <= '0;
      if (!bus_s.we) begin
        case (ofs)
          mcu_pkg::GPIO_IN_OFS:          bus_s.rdata <= in_q;
          mcu_pkg::GPIO_OUT_OFS:         bus_s.rdata <= gpio_o;
          mcu_pkg::GPIO_EN_OFS:          bus_s.rdata <= gpio_en_o;
          mcu_pkg::GPIO_INTR_EN_OFS:     bus_s.rdata <= mcu_pkg::data_t'(intr_en_q);
          mcu_pkg::GPIO_INTR_STATUS_OFS: bus_s.rdata <= mcu_pkg::data_t'(status_q);
          default: ;
        endcase
      end
    end
  end

  assign gpio_intr_o = status_q & intr_en_q;

endmodule

`default_nettype wire

/* soc_ctrl.sv */
/*
  Always-on control registers: program exit value, exit flag and boot select.
  Byte enables are ignored; unknown offsets read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           boot_select_i,
  obi_if.sub             bus_s,
  output logic           exit_valid_o,
  output mcu_pkg::data_t exit_value_o
);

  logic [11:0] ofs;

  assign ofs = bus_s.addr[11:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      bus_s.rvalid <= 1'b0;
    end else begin
      bus_s.rvalid <= bus_s.req;
      if (bus_s.req && bus_s.we) begin
        case (ofs)
          mcu_pkg::EXIT_VALID_OFS: exit_valid_o <= bus_s.wdata[0];
          mcu_pkg::EXIT_VALUE_OFS: exit_value_o <= bus_s.wdata;
          default: ;
        endcase
      end
    end
  end

  // read data
  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      bus_s.rdata <= '0;
      if (!bus_s.we) begin
        case (ofs)
          mcu_pkg::EXIT_VALID_OFS: bus_s.rdata <= mcu_pkg::data_t'(exit_valid_o);
          mcu_pkg::EXIT_VALUE_OFS: bus_s.rdata <= exit_value_o;
          mcu_pkg::BOOT_SEL_OFS:   bus_s.rdata <= mcu_pkg::data_t'(boot_select_i);
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* ram_bank.sv */
/*
  Single-port word memory, RAM_WORDS deep (a power of two, at least 2).
  Contents are undefined until written; writes return zero data.
*/
`timescale 1ns/1ps
`default_nettype none

module ram_bank #(
  parameter int RAM_WORDS = 256
) (
  input  logic clk_i,
  obi_if.sub   bus_s
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  mcu_pkg::data_t   mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;

  // word index above the byte offset
  assign idx = bus_s.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    bus_s.rvalid <= bus_s.req;
    if (bus_s.req) begin
      if (bus_s.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_s.be[b]) begin
            mem[idx][8*b +: 8] <= bus_s.wdata[8*b +: 8];
          end
        end
        bus_s.rdata <= '0;
      end else begin
        bus_s.rdata <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

/* system_bus.sv */
/*
  Single master, four targets. Grant is combinational and always given.
  Unmapped addresses get a zero response from the decoder one cycle later.
*/
`timescale 1ns/1ps
`default_nettype none

module system_bus #(
  parameter int RAM_WORDS = 256
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           bus_req_i,
  input  logic           bus_we_i,
  input  mcu_pkg::be_t   bus_be_i,
  input  mcu_pkg::addr_t bus_addr_i,
  input  mcu_pkg::data_t bus_wdata_i,
  output logic           bus_gnt_o,
  output logic           bus_rvalid_o,
  output mcu_pkg::data_t bus_rdata_o,
  obi_if.mgr             ram_o,
  obi_if.mgr             soc_o,
  obi_if.mgr             gpio_o,
  obi_if.mgr             intr_o
);

  localparam mcu_pkg::addr_t RAM_BYTES = mcu_pkg::addr_t'(RAM_WORDS * 4);

  mcu_pkg::target_e sel;
  mcu_pkg::target_e tgt_q;
  logic             nomap_q;

  function automatic logic in_window(input mcu_pkg::addr_t addr,
                                     input mcu_pkg::addr_t base,
                                     input mcu_pkg::addr_t size);
    return (addr - base) < size;
  endfunction

  always_comb begin
    if (in_window(bus_addr_i, mcu_pkg::RAM_START, RAM_BYTES)) begin
      sel = mcu_pkg::TGT_RAM;
    end else if (in_window(bus_addr_i, mcu_pkg::SOC_CTRL_START, mcu_pkg::PERIPH_SIZE)) begin
      sel = mcu_pkg::TGT_SOC_CTRL;
    end else if (in_window(bus_addr_i, mcu_pkg::GPIO_START, mcu_pkg::PERIPH_SIZE)) begin
      sel = mcu_pkg::TGT_GPIO;
    end else if (in_window(bus_addr_i, mcu_pkg::INTR_START, mcu_pkg::PERIPH_SIZE)) begin
      sel = mcu_pkg::TGT_INTR;
    end else begin
      sel = mcu_pkg::TGT_NONE;
    end
  end

  assign bus_gnt_o = bus_req_i;

  // only the decoded target sees req, the rest is broadcast
  assign ram_o.req   = bus_req_i && (sel == mcu_pkg::TGT_RAM);
  assign ram_o.we    = bus_we_i;
  assign ram_o.be    = bus_be_i;
  assign ram_o.addr  = bus_addr_i;
  assign ram_o.wdata = bus_wdata_i;

  assign soc_o.req   = bus_req_i && (sel == mcu_pkg::TGT_SOC_CTRL);
  assign soc_o.we    = bus_we_i;
  assign soc_o.be    = bus_be_i;
  assign soc_o.addr  = bus_addr_i;
  assign soc_o.wdata = bus_wdata_i;

  assign gpio_o.req   = bus_req_i && (sel == mcu_pkg::TGT_GPIO);
  assign gpio_o.we    = bus_we_i;
  assign gpio_o.be    = bus_be_i;
  assign gpio_o.addr  = bus_addr_i;
  assign gpio_o.wdata = bus_wdata_i;

  assign intr_o.req   = bus_req_i && (sel == mcu_pkg::TGT_INTR);
  assign intr_o.we    = bus_we_i;
  assign intr_o.be    = bus_be_i;
  assign intr_o.addr  = bus_addr_i;
  assign intr_o.wdata = bus_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q   <= mcu_pkg::TGT_NONE;
      nomap_q <= 1'b0;
    end else begin
      tgt_q   <= bus_req_i ? sel : mcu_pkg::TGT_NONE;
      nomap_q <= bus_req_i && (sel == mcu_pkg::TGT_NONE);
    end
  end

  // response of the target addressed one cycle ago
  always_comb begin
    case (tgt_q)
      mcu_pkg::TGT_RAM: begin
        bus_rvalid_o = ram_o.rvalid;
        bus_rdata_o  = ram_o.rdata;
      end
      mcu_pkg::TGT_SOC_CTRL: begin
        bus_rvalid_o = soc_o.rvalid;
        bus_rdata_o  = soc_o.rdata;
      end
      mcu_pkg::TGT_GPIO: begin
        bus_rvalid_o = gpio_o.rvalid;
        bus_rdata_o  = gpio_o.rdata;
      end
      mcu_pkg::TGT_INTR: begin
        bus_rvalid_o = intr_o.rvalid;
        bus_rdata_o  = intr_o.rdata;
      end
      default: begin
        bus_rvalid_o = nomap_q;
        bus_rdata_o  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* obi_if.sv */
/*
  Request/response link between the decoder and one target.
  The target answers every request with a single rvalid pulse one cycle later.
*/
`timescale 1ns/1ps
`default_nettype none

interface obi_if;

  logic            req;
  logic            we;
  mcu_pkg::be_t    be;
  mcu_pkg::addr_t  addr;
  mcu_pkg::data_t  wdata;
  logic            rvalid;
  mcu_pkg::data_t  rdata;

  modport mgr (
    output req, we, be, addr, wdata,
    input  rvalid, rdata
  );

  modport sub (
    input  req, we, be, addr, wdata,
    output rvalid, rdata
  );

endinterface

`default_nettype wire

/* mcu_pkg.sv */
/*
  Shared widths, address map and register offsets of the MCU bus side.
  Register blocks decode only the low 12 address bits of their 4 KiB window.
*/
`default_nettype none

package mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [31:0] gpio_t;
  typedef logic [31:0] irq_vec_t;
  typedef logic [14:0] fast_irq_t;

  // responding target, remembered by the decoder for one cycle
  typedef enum logic [2:0] {
    TGT_RAM,
    TGT_SOC_CTRL,
    TGT_GPIO,
    TGT_INTR,
    TGT_NONE
  } target_e;

  // address map
  localparam addr_t RAM_START      = 32'h0000_0000;
  localparam addr_t SOC_CTRL_START = 32'h2000_0000;
  localparam addr_t GPIO_START     = 32'h2000_1000;
  localparam addr_t INTR_START     = 32'h2000_2000;
  localparam addr_t PERIPH_SIZE    = 32'h0000_1000;

  // soc_ctrl registers
  localparam logic [11:0] EXIT_VALID_OFS = 12'h000;
  localparam logic [11:0] EXIT_VALUE_OFS = 12'h004;
  localparam logic [11:0] BOOT_SEL_OFS   = 12'h008;

  // gpio_ctrl registers
  localparam logic [11:0] GPIO_IN_OFS          = 12'h000;
  localparam logic [11:0] GPIO_OUT_OFS         = 12'h004;
  localparam logic [11:0] GPIO_EN_OFS          = 12'h008;
  localparam logic [11:0] GPIO_INTR_EN_OFS     = 12'h00C;
  localparam logic [11:0] GPIO_INTR_STATUS_OFS = 12'h010;

  // fast_intr_ctrl registers
  localparam logic [11:0] FAST_PENDING_OFS = 12'h000;
  localparam logic [11:0] FAST_ENABLE_OFS  = 12'h004;

  // interrupt layout
  localparam int GPIO_INTR_NUM = 8;
  localparam int FAST_GPIO_LSB = 6;
  localparam int FAST_EXT_LINE = 14;
  localparam int IRQ_EXT_BIT   = 11;
  localparam int IRQ_FAST_LSB  = 16;

endpackage

`default_nettype wire
